//--- logic/proc_pkg.sv
/* Encodings cover only the kept PISA subset. The cop0 moves share one opcode and
   are told apart by the rs field. Each memory holds MEM_WORDS words indexed by addr[9:2]. */
`default_nettype none

package proc_pkg;

  localparam logic [31:0] RESET_VECTOR = 32'h0000_1000;
  localparam int          MEM_WORDS    = 256;
  localparam int          MEM_IDX_W    = $clog2(MEM_WORDS);
  localparam logic [31:0] NOP_INST     = 32'h0000_0000;

  // Primary opcodes
  localparam logic [5:0] OP_SPECIAL = 6'b000000;
  localparam logic [5:0] OP_J       = 6'b000010;
  localparam logic [5:0] OP_BEQ     = 6'b000100;
  localparam logic [5:0] OP_BNE     = 6'b000101;
  localparam logic [5:0] OP_ADDIU   = 6'b001001;
  localparam logic [5:0] OP_ORI     = 6'b001101;
  localparam logic [5:0] OP_LUI     = 6'b001111;
  localparam logic [5:0] OP_COP0    = 6'b010000;
  localparam logic [5:0] OP_LW      = 6'b100011;

  // Function field of OP_SPECIAL
  localparam logic [5:0] FN_SLL  = 6'b000000;
  localparam logic [5:0] FN_ADDU = 6'b100001;
  localparam logic [5:0] FN_SUBU = 6'b100011;
  localparam logic [5:0] FN_AND  = 6'b100100;
  localparam logic [5:0] FN_OR   = 6'b100101;

  // rs field of OP_COP0
  localparam logic [4:0] COP0_MF = 5'b00000;
  localparam logic [4:0] COP0_MT = 5'b00100;

  // Load strobe targets and writeback source
  localparam logic LOAD_IMEM = 1'b0;
  localparam logic LOAD_DMEM = 1'b1;
  localparam logic WB_ALU    = 1'b0;
  localparam logic WB_MEM    = 1'b1;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLL = 3'd4,
    ALU_CP1 = 3'd5
  } alu_fn_t;

  typedef enum logic [1:0] {
    OP0_SHAMT = 2'd0,
    OP0_RS    = 2'd1,
    OP0_16    = 2'd2
  } op0_sel_t;

  typedef enum logic [2:0] {
    OP1_RT   = 3'd0,
    OP1_SEXT = 3'd1,
    OP1_PC4  = 3'd2,
    OP1_ZEXT = 3'd3,
    OP1_MNGR = 3'd4
  } op1_sel_t;

  typedef enum logic [1:0] {
    PC_PLUS4 = 2'd0,
    PC_BR    = 2'd1,
    PC_J     = 2'd2
  } pc_sel_t;

  typedef struct packed {
    pc_sel_t    pc_sel;
    logic       reg_en_f;
    logic       reg_en_d;
    logic       reg_en_x;
    logic       reg_en_m;
    logic       reg_en_w;
    op0_sel_t   op0_sel;
    op1_sel_t   op1_sel;
    alu_fn_t    alu_fn_x;
    logic       wb_sel_m;
    logic [4:0] rf_waddr_w;
    logic       rf_wen_w;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] inst_d;
    logic        br_eq_x;
  } status_t;

  typedef struct packed {
    logic        val;
    logic        target;
    logic [31:0] addr;
    logic [31:0] data;
  } load_t;

  typedef struct packed {
    logic        val;
    logic [31:0] data;
  } mngr_msg_t;

endpackage

`default_nettype wire

//--- logic/proc_alu.sv
/* Shift amount is in0[4:0] and in1 is the value shifted. */
`timescale 1ns/1ps
`default_nettype none

module proc_alu (
  input  logic [31:0]       in0,
  input  logic [31:0]       in1,
  input  proc_pkg::alu_fn_t fn,
  output logic [31:0]       out,
  output logic              ops_eq
);

  always_comb begin
    case (fn)
      proc_pkg::ALU_ADD: out = in0 + in1;
      proc_pkg::ALU_SUB: out = in0 - in1;
      proc_pkg::ALU_AND: out = in0 & in1;
      proc_pkg::ALU_OR:  out = in0 | in1;
      proc_pkg::ALU_SLL: out = in1 << in0[4:0];
      proc_pkg::ALU_CP1: out = in1;
      default:           out = 32'd0;
    endcase
  end

  // Branch compare
  assign ops_eq = (in0 == in1);

endmodule

`default_nettype wire

//--- logic/proc_regfile.sv
/* Register zero always reads as zero. A write in the same cycle as a read of
   that register is returned on the read port. */
`timescale 1ns/1ps
`default_nettype none

module proc_regfile (
  input  logic        clk,
  input  logic [4:0]  read_addr0,
  output logic [31:0] read_data0,
  input  logic [4:0]  read_addr1,
  output logic [31:0] read_data1,
  input  logic        write_en,
  input  logic [4:0]  write_addr,
  input  logic [31:0] write_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  // Write-through covers a writer sitting in W
  assign read_data0 = (read_addr0 == 5'd0) ? 32'd0 :
                      (write_en && write_addr == read_addr0) ? write_data : regs[read_addr0];
  assign read_data1 = (read_addr1 == 5'd0) ? 32'd0 :
                      (write_en && write_addr == read_addr1) ? write_data : regs[read_addr1];

endmodule

`default_nettype wire

//--- logic/proc_mem.sv
/* One-cycle registered read, no reset of contents. Addresses wrap on the
   word index, and only loads whose target matches load_target_id are written. */
`timescale 1ns/1ps
`default_nettype none

module proc_mem (
  input  logic            clk,
  input  proc_pkg::load_t load,
  input  logic            load_target_id,
  input  logic [31:0]     raddr,
  output logic [31:0]     rdata
);

  logic [31:0] mem [proc_pkg::MEM_WORDS];

  always_ff @(posedge clk) begin
    if (load.val && load.target == load_target_id) begin
      mem[load.addr[proc_pkg::MEM_IDX_W+1:2]] <= load.data;
    end
  end

  always_ff @(posedge clk) begin
    rdata <= mem[raddr[proc_pkg::MEM_IDX_W+1:2]];
  end

endmodule

`default_nettype wire

//--- logic/proc_pc_counter.sv
/* pc_next_f is the value the pc takes at the next edge, so it doubles as the
   imem read address. It equals pc_f while fetch is held. */
`timescale 1ns/1ps
`default_nettype none

module proc_pc_counter (
  input  logic              clk,
  input  logic              reset,
  input  logic              en,
  input  proc_pkg::pc_sel_t pc_sel,
  input  logic [31:0]       br_target,
  input  logic [31:0]       j_target,
  output logic [31:0]       pc_f,
  output logic [31:0]       pc_plus4_f,
  output logic [31:0]       pc_next_f
);

  logic [31:0] pc_target;

  assign pc_plus4_f = pc_f + 32'd4;

  always_comb begin
    case (pc_sel)
      proc_pkg::PC_BR: pc_target = br_target;
      proc_pkg::PC_J:  pc_target = j_target;
      default:         pc_target = pc_plus4_f;
    endcase
  end

  // Re-read the same word while stalled
  assign pc_next_f = en ? pc_target : pc_f;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= proc_pkg::RESET_VECTOR - 32'd4;
    end else begin
      pc_f <= pc_next_f;
    end
  end

endmodule

`default_nettype wire

//--- logic/proc_ctrl.sv
/* No bypassing. Any RAW hazard on X or M stalls D until the writer reaches W.
   A taken branch in X wins over a jump in D. Unknown encodings decode as a nop. */
`timescale 1ns/1ps
`default_nettype none

module proc_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  proc_pkg::status_t status,
  output proc_pkg::ctrl_t   ctrl,
  output logic              to_mngr_val
);

  // Control fields that travel with an instruction
  typedef struct packed {
    proc_pkg::alu_fn_t alu_fn;
    logic              rf_wen;
    logic [4:0]        rf_waddr;
    logic              wb_sel;
    logic              mngr_out;
    logic              br_eq;
    logic              br_ne;
  } stage_cw_t;

  logic                val_f;
  logic                val_d;
  logic                val_x;
  logic                val_m;
  logic                val_w;
  stage_cw_t           cw_d;
  stage_cw_t           cw_x;
  stage_cw_t           cw_m;
  stage_cw_t           cw_w;
  logic [5:0]          opcode_d;
  logic [5:0]          funct_d;
  logic [4:0]          rs_d;
  logic [4:0]          rt_d;
  logic [4:0]          rd_d;
  logic                rs_used_d;
  logic                rt_used_d;
  logic                jump_d;
  proc_pkg::op0_sel_t  op0_sel_d;
  proc_pkg::op1_sel_t  op1_sel_d;
  logic                raw_x;
  logic                raw_m;
  logic                stall_d;
  logic                br_taken_x;
  logic                jump_taken_d;
  logic                squash_f;

  assign opcode_d = status.inst_d[31:26];
  assign rs_d     = status.inst_d[25:21];
  assign rt_d     = status.inst_d[20:16];
  assign rd_d     = status.inst_d[15:11];
  assign funct_d  = status.inst_d[5:0];

  //----------------------------------------------------------
  // Decode in D
  //----------------------------------------------------------

  always_comb begin
    cw_d      = '0;
    op0_sel_d = proc_pkg::OP0_RS;
    op1_sel_d = proc_pkg::OP1_RT;
    rs_used_d = 1'b0;
    rt_used_d = 1'b0;
    jump_d    = 1'b0;
    case (opcode_d)
      proc_pkg::OP_SPECIAL: begin
        rs_used_d     = 1'b1;
        rt_used_d     = 1'b1;
        cw_d.rf_wen   = 1'b1;
        cw_d.rf_waddr = rd_d;
        case (funct_d)
          proc_pkg::FN_ADDU: cw_d.alu_fn = proc_pkg::ALU_ADD;
          proc_pkg::FN_SUBU: cw_d.alu_fn = proc_pkg::ALU_SUB;
          proc_pkg::FN_AND:  cw_d.alu_fn = proc_pkg::ALU_AND;
          proc_pkg::FN_OR:   cw_d.alu_fn = proc_pkg::ALU_OR;
          proc_pkg::FN_SLL: begin
            op0_sel_d   = proc_pkg::OP0_SHAMT;
            rs_used_d   = 1'b0;
            cw_d.alu_fn = proc_pkg::ALU_SLL;
          end
          default: begin
            rs_used_d   = 1'b0;
            rt_used_d   = 1'b0;
            cw_d.rf_wen = 1'b0;
          end
        endcase
      end
      proc_pkg::OP_ADDIU, proc_pkg::OP_LW: begin
        rs_used_d     = 1'b1;
        op1_sel_d     = proc_pkg::OP1_SEXT;
        cw_d.alu_fn   = proc_pkg::ALU_ADD;
        cw_d.rf_wen   = 1'b1;
        cw_d.rf_waddr = rt_d;
        cw_d.wb_sel   = (opcode_d == proc_pkg::OP_LW) ? proc_pkg::WB_MEM : proc_pkg::WB_ALU;
      end
      proc_pkg::OP_ORI: begin
        rs_used_d     = 1'b1;
        op1_sel_d     = proc_pkg::OP1_ZEXT;
        cw_d.alu_fn   = proc_pkg::ALU_OR;
        cw_d.rf_wen   = 1'b1;
        cw_d.rf_waddr = rt_d;
      end
      proc_pkg::OP_LUI: begin
        // imm shifted up by the constant 16
        op0_sel_d     = proc_pkg::OP0_16;
        op1_sel_d     = proc_pkg::OP1_ZEXT;
        cw_d.alu_fn   = proc_pkg::ALU_SLL;
        cw_d.rf_wen   = 1'b1;
        cw_d.rf_waddr = rt_d;
      end
      proc_pkg::OP_BEQ, proc_pkg::OP_BNE: begin
        rs_used_d   = 1'b1;
        rt_used_d   = 1'b1;
        cw_d.alu_fn = proc_pkg::ALU_SUB;
        cw_d.br_eq  = (opcode_d == proc_pkg::OP_BEQ);
        cw_d.br_ne  = (opcode_d == proc_pkg::OP_BNE);
      end
      proc_pkg::OP_J: jump_d = 1'b1;
      proc_pkg::OP_COP0: begin
        cw_d.alu_fn = proc_pkg::ALU_CP1;
        if (rs_d == proc_pkg::COP0_MF) begin
          op1_sel_d     = proc_pkg::OP1_MNGR;
          cw_d.rf_wen   = 1'b1;
          cw_d.rf_waddr = rt_d;
        end else if (rs_d == proc_pkg::COP0_MT) begin
          rt_used_d     = 1'b1;
          cw_d.mngr_out = 1'b1;
        end
      end
      default: ;
    endcase
    // r0 is never a real destination, so it never stalls
    if (cw_d.rf_waddr == 5'd0) begin
      cw_d.rf_wen = 1'b0;
    end
  end

  //----------------------------------------------------------
  // Stall and squash
  //----------------------------------------------------------

  assign raw_x = val_x && cw_x.rf_wen &&
                 ((rs_used_d && cw_x.rf_waddr == rs_d) || (rt_used_d && cw_x.rf_waddr == rt_d));
  assign raw_m = val_m && cw_m.rf_wen &&
                 ((rs_used_d && cw_m.rf_waddr == rs_d) || (rt_used_d && cw_m.rf_waddr == rt_d));

  assign br_taken_x   = val_x && ((cw_x.br_eq && status.br_eq_x) ||
                                  (cw_x.br_ne && !status.br_eq_x));
  assign jump_taken_d = val_d && jump_d && !br_taken_x;
  assign stall_d      = val_d && (raw_x || raw_m) && !br_taken_x;
  assign squash_f     = br_taken_x || jump_taken_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      val_f <= 1'b0;
      val_d <= 1'b0;
      val_x <= 1'b0;
      val_m <= 1'b0;
      val_w <= 1'b0;
    end else begin
      val_f <= 1'b1;
      if (!stall_d) begin
        val_d <= val_f && !squash_f;
      end
      val_x <= val_d && !stall_d && !br_taken_x;
      val_m <= val_x;
      val_w <= val_m;
    end
  end

  // Only meaningful while the matching valid bit is set
  always_ff @(posedge clk) begin
    cw_x <= cw_d;
    cw_m <= cw_x;
    cw_w <= cw_m;
  end

  always_comb begin
    if (br_taken_x) begin
      ctrl.pc_sel = proc_pkg::PC_BR;
    end else if (jump_taken_d) begin
      ctrl.pc_sel = proc_pkg::PC_J;
    end else begin
      ctrl.pc_sel = proc_pkg::PC_PLUS4;
    end
    ctrl.reg_en_f   = !stall_d;
    ctrl.reg_en_d   = !stall_d;
    ctrl.reg_en_x   = val_d && !stall_d && !br_taken_x;
    ctrl.reg_en_m   = val_x;
    ctrl.reg_en_w   = val_m;
    ctrl.op0_sel    = op0_sel_d;
    ctrl.op1_sel    = op1_sel_d;
    ctrl.alu_fn_x   = cw_x.alu_fn;
    ctrl.wb_sel_m   = cw_m.wb_sel;
    ctrl.rf_waddr_w = cw_w.rf_waddr;
    ctrl.rf_wen_w   = val_w && cw_w.rf_wen;
  end

  assign to_mngr_val = val_w && cw_w.mngr_out;

endmodule

`default_nettype wire

//--- logic/proc_dpath.sv
/* Operands are read and muxed in D, the ALU runs in X, load data joins in M.
   dmem is addressed by the X ALU result, and its data returns in M. */
`timescale 1ns/1ps
`default_nettype none

module proc_dpath (
  input  logic              clk,
  input  logic              reset,
  input  proc_pkg::ctrl_t   ctrl,
  output proc_pkg::status_t status,
  input  logic [31:0]       imem_rdata,
  output logic [31:0]       imem_addr,
  output logic [31:0]       dmem_addr,
  input  logic [31:0]       dmem_rdata,
  input  logic [31:0]       from_mngr_data,
  output logic [31:0]       to_mngr_data
);

  //----------------------------------------------------------
  // F stage
  //----------------------------------------------------------

  logic [31:0] pc_plus4_f;
  logic [31:0] pc_next_f;
  logic [31:0] br_target_x;
  logic [31:0] j_target_d;

  proc_pc_counter i_pc_counter (
    .clk        (clk),
    .reset      (reset),
    .en         (ctrl.reg_en_f),
    .pc_sel     (ctrl.pc_sel),
    .br_target  (br_target_x),
    .j_target   (j_target_d),
    .pc_f       (),
    .pc_plus4_f (pc_plus4_f),
    .pc_next_f  (pc_next_f)
  );

  assign imem_addr = pc_next_f;

  //----------------------------------------------------------
  // D stage
  //----------------------------------------------------------

  logic [31:0] inst_d;
  logic [31:0] pc_plus4_d;
  logic [31:0] imm_sext_d;
  logic [31:0] imm_zext_d;
  logic [31:0] rf_rdata0_d;
  logic [31:0] rf_rdata1_d;
  logic [31:0] op0_d;
  logic [31:0] op1_d;
  logic [31:0] br_target_d;
  logic [31:0] wb_result_w;

  always_ff @(posedge clk) begin
    if (reset) begin
      inst_d <= proc_pkg::NOP_INST;
    end else if (ctrl.reg_en_d) begin
      inst_d <= imem_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  assign imm_sext_d = {{16{inst_d[15]}}, inst_d[15:0]};
  assign imm_zext_d = {16'd0, inst_d[15:0]};

  proc_regfile i_regfile (
    .clk        (clk),
    .read_addr0 (inst_d[25:21]),
    .read_data0 (rf_rdata0_d),
    .read_addr1 (inst_d[20:16]),
    .read_data1 (rf_rdata1_d),
    .write_en   (ctrl.rf_wen_w),
    .write_addr (ctrl.rf_waddr_w),
    .write_data (wb_result_w)
  );

  always_comb begin
    case (ctrl.op0_sel)
      proc_pkg::OP0_SHAMT: op0_d = {27'd0, inst_d[10:6]};
      proc_pkg::OP0_16:    op0_d = 32'd16;
      default:             op0_d = rf_rdata0_d;
    endcase
    case (ctrl.op1_sel)
      proc_pkg::OP1_SEXT: op1_d = imm_sext_d;
      proc_pkg::OP1_PC4:  op1_d = pc_plus4_d;
      proc_pkg::OP1_ZEXT: op1_d = imm_zext_d;
      proc_pkg::OP1_MNGR: op1_d = from_mngr_data;
      default:            op1_d = rf_rdata1_d;
    endcase
  end

  assign br_target_d = pc_plus4_d + {imm_sext_d[29:0], 2'b00};
  assign j_target_d  = {pc_plus4_d[31:28], inst_d[25:0], 2'b00};

  //----------------------------------------------------------
  // X, M and W stages
  //----------------------------------------------------------

  logic [31:0] op0_x;
  logic [31:0] op1_x;
  logic [31:0] alu_result_x;
  logic [31:0] ex_result_m;
  logic [31:0] wb_result_m;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_x) begin
      op0_x       <= op0_d;
      op1_x       <= op1_d;
      br_target_x <= br_target_d;
    end
  end

  proc_alu i_alu (
    .in0    (op0_x),
    .in1    (op1_x),
    .fn     (ctrl.alu_fn_x),
    .out    (alu_result_x),
    .ops_eq (status.br_eq_x)
  );

  assign dmem_addr = alu_result_x;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_m) begin
      ex_result_m <= alu_result_x;
    end
  end

  assign wb_result_m = (ctrl.wb_sel_m == proc_pkg::WB_MEM) ? dmem_rdata : ex_result_m;

  always_ff @(posedge clk) begin
    if (ctrl.reg_en_w) begin
      wb_result_w <= wb_result_m;
    end
  end

  assign to_mngr_data  = wb_result_w;
  assign status.inst_d = inst_d;

endmodule

`default_nettype wire

//--- logic/proc_top.sv
/* Both memories answer in one cycle. Load them while reset is held.
   to_mngr.val is a one-cycle strobe per mtc0 with no back-pressure. */
`timescale 1ns/1ps
`default_nettype none

module proc_top (
  input  logic                clk,
  input  logic                reset,
  input  proc_pkg::load_t     load,
  input  logic [31:0]         from_mngr_data,
  output proc_pkg::mngr_msg_t to_mngr
);

  proc_pkg::ctrl_t   ctrl;
  proc_pkg::status_t status;
  logic [31:0]       imem_addr;
  logic [31:0]       imem_rdata;
  logic [31:0]       dmem_addr;
  logic [31:0]       dmem_rdata;

  proc_ctrl i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .status      (status),
    .ctrl        (ctrl),
    .to_mngr_val (to_mngr.val)
  );

  proc_dpath i_dpath (
    .clk            (clk),
    .reset          (reset),
    .ctrl           (ctrl),
    .status         (status),
    .imem_rdata     (imem_rdata),
    .imem_addr      (imem_addr),
    .dmem_addr      (dmem_addr),
    .dmem_rdata     (dmem_rdata),
    .from_mngr_data (from_mngr_data),
    .to_mngr_data   (to_mngr.data)
  );

  proc_mem i_imem (
    .clk            (clk),
    .load           (load),
    .load_target_id (proc_pkg::LOAD_IMEM),
    .raddr          (imem_addr),
    .rdata          (imem_rdata)
  );

  proc_mem i_dmem (
    .clk            (clk),
    .load           (load),
    .load_target_id (proc_pkg::LOAD_DMEM),
    .raddr          (dmem_addr),
    .rdata          (dmem_rdata)
  );

endmodule

`default_nettype wire

//--- tests/proc_tb.sv
/* Programs run from RESET_VECTOR and end in a jump to self. Data words sit at 0x100.
   Reset covers the load phase and then 10 more cycles. Results are sampled on the falling edge. */
`timescale 1ns/1ps
`default_nettype none

module proc_tb;

  typedef struct packed {
    logic [15:0][31:0] prog;
    logic [1:0][31:0]  dat;
    logic              use_lfsr;
    logic              mid_reset;
    logic [31:0]       mngr;
    logic [3:0][31:0]  exp;
    logic [2:0]        exp_n;
  } test_t;

  logic                clk = 1'b0;
  logic                reset;
  proc_pkg::load_t     load;
  logic [31:0]         from_mngr_data;
  proc_pkg::mngr_msg_t to_mngr;

  test_t       tests [5];
  logic [31:0] lfsr_state = 32'h97b3;
  logic [31:0] rand_value;
  int          mismatches = 0;
  int          timeouts = 0;
  int          strays = 0;
  int          t;

  always #5 clk = ~clk;

  proc_top i_proc_top (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .from_mngr_data (from_mngr_data),
    .to_mngr        (to_mngr)
  );

  // ------------------------------------------------------------
  // Instruction encoding
  // ------------------------------------------------------------

  function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] shamt);
    return {proc_pkg::OP_SPECIAL, rs, rt, rd, shamt, funct};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Target is a word index into the program
  function automatic logic [31:0] jump_to(input int idx);
    logic [31:0] addr;
    addr = proc_pkg::RESET_VECTOR + 32'(4 * idx);
    return {proc_pkg::OP_J, addr[27:2]};
  endfunction

  function automatic logic [31:0] move_from_mngr(input logic [4:0] rt);
    return {proc_pkg::OP_COP0, proc_pkg::COP0_MF, rt, 16'd0};
  endfunction

  function automatic logic [31:0] move_to_mngr(input logic [4:0] rt);
    return {proc_pkg::OP_COP0, proc_pkg::COP0_MT, rt, 16'd0};
  endfunction

  // ------------------------------------------------------------
  // Random values and reference results
  // ------------------------------------------------------------

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_random(output logic [31:0] value);
    int b;
    value = '0;
    for (b = 0; b < 32; b++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Register r6 after the arithmetic chain of test 0
  function automatic logic [31:0] chain_result(input logic [31:0] v);
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    r2 = v + 32'd5;
    r3 = r2 + v;
    r4 = r3 - v;
    r5 = r4 & r3;
    return r5 | v;
  endfunction

  task automatic build_table();
    int i;
    for (i = 0; i < 5; i++) begin
      tests[i] = '0;
    end
    // Arithmetic on the manager value
    tests[0].use_lfsr = 1'b1;
    tests[0].prog[0]  = move_from_mngr(5'd1);
    tests[0].prog[1]  = itype(proc_pkg::OP_ADDIU, 5'd2, 5'd1, 16'd5);
    tests[0].prog[2]  = rtype(proc_pkg::FN_ADDU, 5'd3, 5'd2, 5'd1, 5'd0);
    tests[0].prog[3]  = rtype(proc_pkg::FN_SUBU, 5'd4, 5'd3, 5'd1, 5'd0);
    tests[0].prog[4]  = rtype(proc_pkg::FN_AND, 5'd5, 5'd4, 5'd3, 5'd0);
    tests[0].prog[5]  = rtype(proc_pkg::FN_OR, 5'd6, 5'd5, 5'd1, 5'd0);
    tests[0].prog[6]  = move_to_mngr(5'd2);
    tests[0].prog[7]  = move_to_mngr(5'd6);
    tests[0].prog[8]  = jump_to(8);
    tests[0].exp_n    = 3'd2;
    // RAW at X, M and W distance
    tests[1].prog[0]  = itype(proc_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd7);
    tests[1].prog[1]  = itype(proc_pkg::OP_ADDIU, 5'd2, 5'd1, 16'd3);
    tests[1].prog[2]  = itype(proc_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd100);
    tests[1].prog[3]  = rtype(proc_pkg::FN_SUBU, 5'd4, 5'd2, 5'd1, 5'd0);
    tests[1].prog[4]  = itype(proc_pkg::OP_ADDIU, 5'd5, 5'd0, 16'd1);
    tests[1].prog[5]  = itype(proc_pkg::OP_ADDIU, 5'd6, 5'd0, 16'd2);
    tests[1].prog[6]  = rtype(proc_pkg::FN_ADDU, 5'd7, 5'd4, 5'd3, 5'd0);
    tests[1].prog[7]  = move_to_mngr(5'd2);
    tests[1].prog[8]  = move_to_mngr(5'd4);
    tests[1].prog[9]  = move_to_mngr(5'd7);
    tests[1].prog[10] = jump_to(10);
    tests[1].exp      = {32'd0, 32'd103, 32'd3, 32'd10};
    tests[1].exp_n    = 3'd3;
    // Constant build and loads
    tests[2].prog[0]  = itype(proc_pkg::OP_LUI, 5'd1, 5'd0, 16'h1234);
    tests[2].prog[1]  = itype(proc_pkg::OP_ORI, 5'd1, 5'd1, 16'h5678);
    tests[2].prog[2]  = rtype(proc_pkg::FN_SLL, 5'd2, 5'd0, 5'd1, 5'd4);
    tests[2].prog[3]  = itype(proc_pkg::OP_LW, 5'd3, 5'd0, 16'h0100);
    tests[2].prog[4]  = itype(proc_pkg::OP_LW, 5'd4, 5'd0, 16'h0104);
    tests[2].prog[5]  = rtype(proc_pkg::FN_ADDU, 5'd5, 5'd3, 5'd4, 5'd0);
    tests[2].prog[6]  = move_to_mngr(5'd2);
    tests[2].prog[7]  = move_to_mngr(5'd3);
    tests[2].prog[8]  = move_to_mngr(5'd5);
    tests[2].prog[9]  = jump_to(9);
    tests[2].dat      = {32'h0000_0101, 32'h1357_9bdf};
    tests[2].exp      = {32'd0, 32'h1357_9ce0, 32'h1357_9bdf, 32'h2345_6780};
    tests[2].exp_n    = 3'd3;
    // Branches and jumps, r4 marks the wrong path
    tests[3].prog[0]  = itype(proc_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd5);
    tests[3].prog[1]  = itype(proc_pkg::OP_ADDIU, 5'd2, 5'd0, 16'd5);
    tests[3].prog[2]  = itype(proc_pkg::OP_ADDIU, 5'd3, 5'd0, 16'd9);
    tests[3].prog[3]  = itype(proc_pkg::OP_ADDIU, 5'd4, 5'd0, 16'h77);
    // Jump in D and mtc0 in F behind a taken branch
    tests[3].prog[4]  = itype(proc_pkg::OP_BEQ, 5'd2, 5'd1, 16'd2);
    tests[3].prog[5]  = jump_to(14);
    tests[3].prog[6]  = move_to_mngr(5'd4);
    tests[3].prog[7]  = itype(proc_pkg::OP_BNE, 5'd2, 5'd1, 16'd1);
    tests[3].prog[8]  = move_to_mngr(5'd1);
    tests[3].prog[9]  = itype(proc_pkg::OP_BNE, 5'd3, 5'd1, 16'd1);
    tests[3].prog[10] = move_to_mngr(5'd4);
    tests[3].prog[11] = itype(proc_pkg::OP_BEQ, 5'd3, 5'd1, 16'd1);
    tests[3].prog[12] = move_to_mngr(5'd3);
    tests[3].prog[13] = jump_to(15);
    tests[3].prog[14] = move_to_mngr(5'd4);
    tests[3].prog[15] = jump_to(15);
    tests[3].exp      = {32'd0, 32'd0, 32'd9, 32'd5};
    tests[3].exp_n    = 3'd2;
    // Reset after the first result, then a full rerun
    tests[4].mid_reset = 1'b1;
    tests[4].prog[0]  = itype(proc_pkg::OP_ADDIU, 5'd1, 5'd0, 16'h11);
    tests[4].prog[1]  = move_to_mngr(5'd1);
    tests[4].prog[2]  = itype(proc_pkg::OP_ADDIU, 5'd2, 5'd1, 16'h22);
    tests[4].prog[3]  = rtype(proc_pkg::FN_ADDU, 5'd3, 5'd2, 5'd2, 5'd0);
    tests[4].prog[4]  = move_to_mngr(5'd3);
    tests[4].prog[5]  = move_to_mngr(5'd2);
    tests[4].prog[6]  = jump_to(6);
    tests[4].exp      = {32'd0, 32'h33, 32'h66, 32'h11};
    tests[4].exp_n    = 3'd3;
  endtask

  // ------------------------------------------------------------
  // Drive, wait and check
  // ------------------------------------------------------------

  task automatic load_word(input logic target, input logic [31:0] addr,
                           input logic [31:0] data);
    proc_pkg::load_t l;
    l.val    = 1'b1;
    l.target = target;
    l.addr   = addr;
    l.data   = data;
    @(posedge clk);
    load <= l;
  endtask

  task automatic wait_strobe(output logic got, output proc_pkg::mngr_msg_t msg);
    int n;
    got = 1'b0;
    msg = '0;
    for (n = 0; n < 200 && !got; n++) begin
      @(negedge clk);
      if (to_mngr.val === 1'b1) begin
        got = 1'b1;
        msg = to_mngr;
      end
    end
  endtask

  task automatic check_mngr(input proc_pkg::mngr_msg_t got, input logic [31:0] exp,
                            input int test, input int idx);
    if (got.data !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: test %0d result %0d got %h expected %h",
               $time, test, idx, got.data, exp);
    end
  endtask

  // to_mngr must stay quiet for the given number of cycles
  task automatic check_quiet(input int cycles, input int test);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(negedge clk);
      if (to_mngr.val !== 1'b0) begin
        strays++;
        $display("Unexpected to_mngr strobe at %0t in test %0d with data %h",
                 $time, test, to_mngr.data);
      end
    end
  endtask

  task automatic run_test(input int test);
    test_t               tc;
    proc_pkg::mngr_msg_t msg;
    logic                got;
    int                  k;
    tc = tests[test];
    @(posedge clk);
    reset          <= 1'b1;
    from_mngr_data <= tc.mngr;
    for (k = 0; k < 16; k++) begin
      load_word(proc_pkg::LOAD_IMEM, proc_pkg::RESET_VECTOR + 32'(4 * k), tc.prog[k]);
    end
    for (k = 0; k < 2; k++) begin
      load_word(proc_pkg::LOAD_DMEM, 32'h100 + 32'(4 * k), tc.dat[k]);
    end
    @(posedge clk);
    load <= '0;
    repeat (9) @(posedge clk);
    @(posedge clk);
    reset <= 1'b0;
    if (tc.mid_reset) begin
      wait_strobe(got, msg);
      if (!got) begin
        timeouts++;
        $display("Timeout at %0t: test %0d saw no first result within 200 cycles", $time, test);
        return;
      end
      check_mngr(msg, tc.exp[0], test, 0);
      @(posedge clk);
      reset <= 1'b1;
      check_quiet(10, test);
      @(posedge clk);
      reset <= 1'b0;
    end
    for (k = 0; k < tc.exp_n; k++) begin
      wait_strobe(got, msg);
      if (!got) begin
        timeouts++;
        $display("Timeout at %0t: test %0d saw no result %0d within 200 cycles",
                 $time, test, k);
        return;
      end
      check_mngr(msg, tc.exp[k], test, k);
    end
    check_quiet(30, test);
  endtask

  initial begin
    reset          = 1'b1;
    load           = '0;
    from_mngr_data = '0;
    build_table();
    for (t = 0; t < 5; t++) begin
      if (tests[t].use_lfsr) begin
        draw_random(rand_value);
        tests[t].mngr   = rand_value;
        tests[t].exp[0] = rand_value + 32'd5;
        tests[t].exp[1] = chain_result(rand_value);
      end
      run_test(t);
    end
    $display("Errors: %0d mismatches, %0d timeouts, %0d unexpected strobes",
             mismatches, timeouts, strays);
    if (mismatches + timeouts + strays == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- proc.f
logic/proc_pkg.sv
logic/proc_alu.sv
logic/proc_regfile.sv
logic/proc_mem.sv
logic/proc_pc_counter.sv
logic/proc_ctrl.sv
logic/proc_dpath.sv
logic/proc_top.sv
tests/proc_tb.sv
